// File: tb.f
+incdir+verif
common/pdp8_pkg.sv
verilog/phase_sequencer.sv
verilog/operate_unit.sv
verilog/ac_mq_regs.sv
eae/eae_unit.sv
verilog/ac_unit.sv
verif/ac_unit_tb.sv

// File: Bender.yml
package:
  name: pdp8_ac

sources:
  - files:
      - common/pdp8_pkg.sv
      - verilog/phase_sequencer.sv
      - verilog/operate_unit.sv
      - verilog/ac_mq_regs.sv
      - eae/eae_unit.sv
      - verilog/ac_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/ac_unit_tb.sv

// File: verif/ac_model.svh
`ifndef AC_MODEL_SVH
`define AC_MODEL_SVH

// architectural state expected after each instruction
pdp8_pkg::word_t model_ac;
pdp8_pkg::word_t model_mq;
logic            model_link;

function automatic bit is_eae(input pdp8_pkg::word_t word);
    return word == pdp8_pkg::EAE_MUL || word == pdp8_pkg::EAE_DIV ||
           word == pdp8_pkg::EAE_SHL || word == pdp8_pkg::EAE_ASR ||
           word == pdp8_pkg::EAE_LSR;
endfunction

function automatic bit is_mq_code(input pdp8_pkg::word_t word);
    return word == pdp8_pkg::MQ_MQL || word == pdp8_pkg::MQ_MQA ||
           word == pdp8_pkg::MQ_SWP || word == pdp8_pkg::MQ_CLA ||
           word == pdp8_pkg::MQ_CAM || word == pdp8_pkg::MQ_ACL;
endfunction

task automatic model_clear();
    model_ac   = 12'o0000;
    model_mq   = 12'o0000;
    model_link = 1'b0;
endtask

// clear, complement, increment, then rotate
task automatic model_group1(input pdp8_pkg::word_t word);
    logic [12:0] la;  // link on top of ac
    la = {model_link, model_ac};
    if ((word & 12'o0200) != 0)
        la[11:0] = 12'o0000;
    if ((word & 12'o0100) != 0)
        la[12] = 1'b0;
    if ((word & 12'o0040) != 0)
        la[11:0] = ~la[11:0];
    if ((word & 12'o0020) != 0)
        la[12] = ~la[12];
    if ((word & 12'o0001) != 0)
    begin
        if (la[11:0] == 12'o7777)
            la[12] = ~la[12];  // carry out of ac
        la[11:0] = la[11:0] + 12'd1;
    end
    case (word & 12'o0016)
        12'o0002: la[11:0] = {la[5:0], la[11:6]};  // byte swap
        12'o0004: la = {la[11:0], la[12]};
        12'o0006: la = {la[10:0], la[12:11]};
        12'o0010: la = {la[0], la[12:1]};
        12'o0012: la = {la[1:0], la[12:2]};
        default: ;  // no rotate, or an undefined mix
    endcase
    {model_link, model_ac} = la;
endtask

// cla first, then mqa and mql together
task automatic model_group3(input pdp8_pkg::word_t word);
    pdp8_pkg::word_t cleared;
    cleared = ((word & 12'o0200) != 0) ? 12'o0000 : model_ac;
    if ((word & 12'o0020) != 0)
    begin
        model_ac = ((word & 12'o0100) != 0) ? model_mq : 12'o0000;  // swap with mqa
        model_mq = cleared;
    end
    else if ((word & 12'o0100) != 0)
        model_ac = cleared | model_mq;
    else
        model_ac = cleared;
endtask

task automatic model_memref(input logic [2:0] opcode, input pdp8_pkg::word_t opnd);
    int sum;
    sum = int'(model_ac) + int'(opnd);
    case (opcode)
        3'o0: model_ac = model_ac & opnd;
        3'o1:
        begin
            if (sum > 12'o7777)
                model_link = ~model_link;  // carry out of ac
            model_ac = 12'(sum);
        end
        3'o3: model_ac = 12'o0000;  // word goes to memory
        default: ;
    endcase
endtask

task automatic model_eae(input pdp8_pkg::word_t word, input pdp8_pkg::word_t opnd);
    logic [23:0]        pair;  // ac above mq
    logic signed [23:0] spair;
    logic [24:0]        wide;  // link, ac, mq
    logic [23:0]        quotient;
    logic [23:0]        remainder;
    int                 shift;
    pair  = {model_ac, model_mq};
    shift = int'(opnd & 12'o0037) + 1;
    case (word)
        pdp8_pkg::EAE_MUL:
        begin
            pair       = 24'(model_mq) * 24'(opnd) + 24'(model_ac);
            model_link = 1'b0;
        end
        pdp8_pkg::EAE_DIV:
            if (model_ac < opnd)
            begin
                quotient   = pair / 24'(opnd);
                remainder  = pair % 24'(opnd);
                pair       = {remainder[11:0], quotient[11:0]};
                model_link = 1'b0;
            end
            else
                model_link = 1'b1;  // overflow, registers kept
        pdp8_pkg::EAE_SHL:
        begin
            wide               = {1'b0, pair} << shift;
            {model_link, pair} = wide;
        end
        pdp8_pkg::EAE_LSR:
        begin
            pair       = pair >> shift;
            model_link = 1'b0;
        end
        pdp8_pkg::EAE_ASR:
        begin
            model_link = model_ac[0];
            spair      = pair;
            pair       = spair >>> shift;
        end
        default: ;
    endcase
    {model_ac, model_mq} = pair;
endtask

task automatic model_execute(input pdp8_pkg::word_t word, input pdp8_pkg::word_t opnd);
    logic [2:0] opcode;
    opcode = word[0:2];
    if (opcode != 3'o7)
        model_memref(opcode, opnd);
    else if (word[3] == 1'b0)
        model_group1(word);
    else if (is_eae(word))
        model_eae(word, opnd);
    else if (is_mq_code(word))
        model_group3(word);
endtask

`endif

// File: verif/ac_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ac_unit_tb;

    localparam int DONE_TIMEOUT = 64;  // cycles, the longest shift needs 27
    localparam int ROUNDS       = 40;

    logic             clk;
    logic             reset;
    logic             start;
    pdp8_pkg::instr_t instruction;
    pdp8_pkg::word_t  operand;
    pdp8_pkg::word_t  ac;
    pdp8_pkg::word_t  mq;
    logic             link;
    logic             busy;
    logic             done;

    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int test_errors;  // error count when the current test began
    bit aborted;

    `include "ac_model.svh"

    ac_unit uut (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .instruction (instruction),
        .operand     (operand),
        .ac          (ac),
        .mq          (mq),
        .link        (link),
        .busy        (busy),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string what, input pdp8_pkg::word_t got,
                              input pdp8_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %o, expected %o", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_steps(input string what, input pdp8_pkg::sc_t got,
                               input pdp8_pkg::sc_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    // runs one instruction and compares the registers while done is high
    task automatic execute(input pdp8_pkg::word_t word, input pdp8_pkg::word_t opnd,
                           input int want_cycles, input bit repeat_start);
        int cycles;
        int i;
        bit seen;
        if (aborted)
            return;
        @(posedge clk);
        instruction <= word;
        operand     <= opnd;
        start       <= 1'b1;
        @(posedge clk);  // start sampled here
        start  <= 1'b0;
        cycles = 0;
        if (repeat_start)
        begin
            @(posedge clk);
            start <= 1'b1;  // lands in eae1
            @(posedge clk);
            start  <= 1'b0;
            cycles = 2;
        end
        seen = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            seen = done;
            if (!seen)
                check_bit($sformatf("busy while running %o", word), busy, 1'b1);
        end
        if (!seen)
        begin
            $display("timeout: no done within %0d cycles of starting %o", DONE_TIMEOUT, word);
            errors++;
            aborted = 1'b1;
            return;
        end
        if (want_cycles > 0)
            check_latency($sformatf("latency of %o", word), cycles, want_cycles);
        model_execute(word, opnd);
        check_word($sformatf("ac after %o", word), ac, model_ac);
        check_word($sformatf("mq after %o", word), mq, model_mq);
        check_bit($sformatf("link after %o", word), link, model_link);
        if (is_eae(word))
            check_steps($sformatf("step counter after %o", word), uut.u_eae.sc, 5'd0);
        if (repeat_start)
            for (i = 0; i < 5; i++)
            begin
                @(negedge clk);
                check_bit("busy after a start while busy", busy, 1'b0);
                check_bit("done after a start while busy", done, 1'b0);
            end
    endtask

    task automatic load_ac(input pdp8_pkg::word_t value, input logic link_value);
        execute(12'o7300, 12'o0000, 4, 1'b0);  // cla cll
        execute({3'o1, 9'($urandom)}, value, 3, 1'b0);  // tad
        if (link_value)
            execute(12'o7020, 12'o0000, 4, 1'b0);  // cml
    endtask

    task automatic load_mq(input pdp8_pkg::word_t value);
        load_ac(value, 1'b0);
        execute(pdp8_pkg::MQ_MQL, 12'o0000, 4, 1'b0);
    endtask

    function automatic pdp8_pkg::word_t mq_code(input int index);
        case (index)
            0:       return pdp8_pkg::MQ_MQL;
            1:       return pdp8_pkg::MQ_MQA;
            2:       return pdp8_pkg::MQ_SWP;
            3:       return pdp8_pkg::MQ_CAM;
            4:       return pdp8_pkg::MQ_ACL;
            default: return pdp8_pkg::MQ_CLA;
        endcase
    endfunction

    function automatic pdp8_pkg::word_t shift_code(input int index);
        case (index)
            0:       return pdp8_pkg::EAE_SHL;
            1:       return pdp8_pkg::EAE_LSR;
            default: return pdp8_pkg::EAE_ASR;
        endcase
    endfunction

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input int number, input string name);
        tests_run++;
        if (errors != test_errors)
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", number, name, errors - test_errors);
        end
        else
            $display("test %0d %s: ok", number, name);
    endtask

    initial
    begin
        int              round;
        int              step;
        int              count;
        logic [2:0]      opcode;
        pdp8_pkg::word_t opnd;
        void'($urandom(32'hfd63));
        reset        = 1'b1;
        start        = 1'b0;
        instruction  = 12'o0000;
        operand      = 12'o0000;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        model_clear();
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        begin_test();
        @(negedge clk);
        check_word("ac after reset", ac, model_ac);
        check_word("mq after reset", mq, model_mq);
        check_bit("link after reset", link, model_link);
        check_bit("busy after reset", busy, 1'b0);
        check_bit("done after reset", done, 1'b0);
        end_test(1, "reset state");

        begin_test();
        for (round = 0; round < ROUNDS; round++)
        begin
            load_ac(12'($urandom), 1'($urandom));
            execute({4'b1110, 8'($urandom)}, 12'($urandom), 4, 1'b0);
        end
        end_test(2, "group 1 operate");

        begin_test();
        for (round = 0; round < ROUNDS; round++)
        begin
            if (1'($urandom))
                execute(12'o7020, 12'o0000, 4, 1'b0);
            step   = $urandom_range(2, 0);
            opcode = (step == 2) ? 3'o3 : 3'(step);
            execute({opcode, 9'($urandom)}, 12'($urandom), 3, 1'b0);
        end
        end_test(3, "and tad dca");

        begin_test();
        for (round = 0; round < ROUNDS / 4; round++)
        begin
            load_mq(12'($urandom));
            load_ac(12'($urandom), 1'b0);
            for (step = 0; step < 8; step++)
                execute(mq_code($urandom_range(5, 0)), 12'($urandom), 4, 1'b0);
        end
        end_test(4, "mq microcodes");

        begin_test();
        for (round = 0; round < ROUNDS / 2; round++)
        begin
            load_mq(12'($urandom));
            load_ac(12'($urandom), 1'($urandom));
            execute(pdp8_pkg::EAE_MUL, 12'($urandom), 0, 1'b0);
            opnd = 12'($urandom_range(4095, 1));
            load_mq(12'($urandom));
            load_ac(12'($urandom % opnd), 1'($urandom));
            execute(pdp8_pkg::EAE_DIV, opnd, 0, 1'b0);
            opnd = 12'($urandom_range(4095, 0));
            load_ac(12'($urandom_range(4095, opnd)), 1'($urandom));
            execute(pdp8_pkg::EAE_DIV, opnd, 0, 1'b0);  // overflow
        end
        end_test(5, "mul and div");

        begin_test();
        for (round = 0; round < ROUNDS; round++)
        begin
            count = (round % 4 == 0) ? $urandom_range(31, 24) : $urandom_range(31, 0);
            load_mq(12'($urandom));
            load_ac(12'($urandom), 1'($urandom));
            execute(shift_code(round % 3), {7'($urandom), 5'(count)}, 0, 1'b0);
        end
        load_mq(12'($urandom));
        load_ac(12'($urandom), 1'b0);
        execute(pdp8_pkg::EAE_MUL, 12'($urandom), 0, 1'b1);
        load_ac(12'o4000 | 12'($urandom), 1'b0);
        execute(pdp8_pkg::EAE_ASR, {7'($urandom), 5'd10}, 0, 1'b1);
        end_test(6, "shifts and start while busy");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !aborted)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ac_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ac_unit (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             start,        // one cycle pulse
    input  wire pdp8_pkg::instr_t instruction,  // held until done, like operand
    input  wire pdp8_pkg::word_t  operand,
    output pdp8_pkg::word_t       ac,
    output pdp8_pkg::word_t       mq,
    output logic                  link,
    output logic                  busy,
    output logic                  done
);

    pdp8_pkg::phase_t phase;
    logic             eae_loop;

    logic             op_we;
    pdp8_pkg::word_t  op_ac;
    pdp8_pkg::word_t  op_mq;
    logic             op_link;

    logic             eae_we;
    pdp8_pkg::word_t  eae_ac;
    pdp8_pkg::word_t  eae_mq;
    logic             eae_link;

    phase_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .instruction (instruction),
        .eae_loop    (eae_loop),
        .phase       (phase),
        .busy        (busy),
        .done        (done)
    );

    operate_unit u_opr (
        .phase       (phase),
        .instruction (instruction),
        .operand     (operand),
        .ac          (ac),
        .mq          (mq),
        .link        (link),
        .op_we       (op_we),
        .ac_next     (op_ac),
        .mq_next     (op_mq),
        .link_next   (op_link)
    );

    eae_unit u_eae (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .operand     (operand),
        .ac          (ac),
        .mq          (mq),
        .link        (link),
        .eae_loop    (eae_loop),
        .eae_we      (eae_we),
        .ac_next     (eae_ac),
        .mq_next     (eae_mq),
        .link_next   (eae_link)
    );

    ac_mq_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .op_we    (op_we),
        .eae_we   (eae_we),
        .op_ac    (op_ac),
        .op_mq    (op_mq),
        .eae_ac   (eae_ac),
        .eae_mq   (eae_mq),
        .op_link  (op_link),
        .eae_link (eae_link),
        .ac       (ac),
        .mq       (mq),
        .link     (link)
    );

endmodule

`default_nettype wire

// File: eae/eae_unit.sv
`timescale 1ns/1ns
`default_nettype none

module eae_unit (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire pdp8_pkg::phase_t phase,
    input  wire pdp8_pkg::instr_t instruction,
    input  wire pdp8_pkg::word_t  operand,
    input  wire pdp8_pkg::word_t  ac,
    input  wire pdp8_pkg::word_t  mq,
    input  wire logic             link,
    output logic                  eae_loop,
    output logic                  eae_we,
    output pdp8_pkg::word_t       ac_next,
    output pdp8_pkg::word_t       mq_next,
    output logic                  link_next
);

    pdp8_pkg::word_t code;
    pdp8_pkg::sc_t   sc;
    pdp8_pkg::sc_t   sc_next;
    pdp8_pkg::sc_t   count;
    logic            loop_next;
    logic            saturate;
    logic [0:12]     div_ov;   // msb set when ac is below the divisor
    logic [0:12]     div_try;  // trial subtract of one quotient step
    logic [0:12]     mul_sum;

    assign code     = instruction;
    assign count    = operand[7:11];
    assign saturate = count >= pdp8_pkg::SHIFT_LIMIT;
    assign div_ov   = {1'b0, ac} - {1'b0, operand};
    assign div_try  = {ac, mq[0]} - {1'b0, operand};
    assign mul_sum  = {1'b0, ac} + {1'b0, (mq[11] ? operand : 12'o0000)};

    always_comb
    begin
        eae_we    = 1'b0;
        ac_next   = ac;
        mq_next   = mq;
        link_next = link;
        sc_next   = sc;
        loop_next = eae_loop;
        case (phase)
            pdp8_pkg::EAE0:
            begin
                eae_we    = 1'b1;
                loop_next = 1'b0;
                case (code)
                    pdp8_pkg::EAE_MUL:
                    begin
                        link_next = 1'b0;
                        sc_next   = 5'd12;
                        loop_next = 1'b1;
                    end
                    pdp8_pkg::EAE_DIV:
                    begin
                        sc_next   = div_ov[0] ? 5'd12 : 5'd0;
                        link_next = !div_ov[0];  // link flags divide overflow
                        loop_next = div_ov[0];
                    end
                    pdp8_pkg::EAE_SHL,
                    pdp8_pkg::EAE_LSR,
                    pdp8_pkg::EAE_ASR:
                    begin
                        // asr keeps the sign in the link, the others shift in zero
                        link_next = (code == pdp8_pkg::EAE_ASR) ? ac[0] : 1'b0;
                        if (saturate)
                        begin
                            ac_next = {12{link_next}};
                            mq_next = {12{link_next}};
                            sc_next = 5'd0;
                        end
                        else
                        begin
                            sc_next   = count + 5'd1;
                            loop_next = 1'b1;
                        end
                    end
                    default: eae_we = 1'b0;
                endcase
            end
            pdp8_pkg::EAE1:
                if (eae_loop)
                begin
                    eae_we    = 1'b1;
                    sc_next   = sc - 5'd1;
                    loop_next = (sc != 5'd1);
                    case (code)
                        pdp8_pkg::EAE_MUL: {ac_next, mq_next} = {mul_sum, mq[0:10]};
                        pdp8_pkg::EAE_DIV:
                            if (!div_try[0])  // divisor fits, keep the difference
                            begin
                                ac_next = div_try[1:12];
                                mq_next = {mq[1:11], 1'b1};
                            end
                            else
                            begin
                                ac_next = {ac[1:11], mq[0]};
                                mq_next = {mq[1:11], 1'b0};
                            end
                        pdp8_pkg::EAE_SHL: {link_next, ac_next, mq_next} = {ac, mq, 1'b0};
                        pdp8_pkg::EAE_ASR,
                        pdp8_pkg::EAE_LSR: {ac_next, mq_next} = {link, ac, mq[0:10]};
                        default:
                        begin
                            eae_we    = 1'b0;
                            loop_next = 1'b0;
                        end
                    endcase
                end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sc       <= 5'd0;
            eae_loop <= 1'b0;
        end
        else
        begin
            sc       <= sc_next;
            eae_loop <= loop_next;
        end
    end

    sc_bound: assert property (@(posedge clk) disable iff (reset) eae_loop |-> sc <= 5'd25);

endmodule

`default_nettype wire

// File: verilog/ac_mq_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ac_mq_regs (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            op_we,
    input  wire logic            eae_we,
    input  wire pdp8_pkg::word_t op_ac,
    input  wire pdp8_pkg::word_t op_mq,
    input  wire pdp8_pkg::word_t eae_ac,
    input  wire pdp8_pkg::word_t eae_mq,
    input  wire logic            op_link,
    input  wire logic            eae_link,
    output pdp8_pkg::word_t      ac,
    output pdp8_pkg::word_t      mq,
    output logic                 link
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ac   <= 12'o0000;
            mq   <= 12'o0000;
            link <= 1'b0;
        end
        else if (op_we)
        begin
            ac   <= op_ac;
            mq   <= op_mq;
            link <= op_link;
        end
        else if (eae_we)
        begin
            ac   <= eae_ac;
            mq   <= eae_mq;
            link <= eae_link;
        end
    end

    // the units own disjoint phases
    one_writer: assert property (@(posedge clk) disable iff (reset) !(op_we && eae_we));

endmodule

`default_nettype wire

// File: verilog/operate_unit.sv
`timescale 1ns/1ns
`default_nettype none

module operate_unit (
    input  wire pdp8_pkg::phase_t phase,
    input  wire pdp8_pkg::instr_t instruction,
    input  wire pdp8_pkg::word_t  operand,
    input  wire pdp8_pkg::word_t  ac,
    input  wire pdp8_pkg::word_t  mq,
    input  wire logic             link,
    output logic                  op_we,
    output pdp8_pkg::word_t       ac_next,
    output pdp8_pkg::word_t       mq_next,
    output logic                  link_next
);

    pdp8_pkg::word_t code;
    logic            group1;

    assign code   = instruction;
    assign group1 = (instruction.opr.opcode == pdp8_pkg::OP_OPR) && !instruction.opr.group;

    always_comb
    begin
        op_we     = 1'b0;
        ac_next   = ac;
        mq_next   = mq;
        link_next = link;
        case (phase)
            pdp8_pkg::F1:
                if (group1)
                begin
                    // clear first, then complement
                    op_we     = instruction.opr.cla | instruction.opr.cll |
                                instruction.opr.cma | instruction.opr.cml;
                    ac_next   = (instruction.opr.cla ? 12'o0000 : ac) ^ {12{instruction.opr.cma}};
                    link_next = (link & ~instruction.opr.cll) ^ instruction.opr.cml;
                end
                else
                begin
                    op_we = 1'b1;
                    case (code)
                        pdp8_pkg::MQ_MQL:
                        begin
                            mq_next = ac;
                            ac_next = 12'o0000;
                        end
                        pdp8_pkg::MQ_MQA: ac_next = ac | mq;
                        pdp8_pkg::MQ_SWP:
                        begin
                            mq_next = ac;
                            ac_next = mq;
                        end
                        pdp8_pkg::MQ_CLA: ac_next = 12'o0000;
                        pdp8_pkg::MQ_CAM:
                        begin
                            mq_next = 12'o0000;
                            ac_next = 12'o0000;
                        end
                        pdp8_pkg::MQ_ACL: ac_next = mq;  // cla then mqa
                        default:          op_we   = 1'b0;
                    endcase
                end
            pdp8_pkg::F2:
                if (group1 && instruction.opr.iac)
                begin
                    op_we                = 1'b1;
                    {link_next, ac_next} = {link, ac} + 13'd1;
                end
            pdp8_pkg::F3:
                if (group1)
                begin
                    op_we = 1'b1;
                    case ({instruction.opr.rar, instruction.opr.ral, instruction.opr.bsw})
                        3'b001: ac_next = {ac[6:11], ac[0:5]};  // bsw
                        3'b010: {link_next, ac_next} = {ac, link};  // ral
                        3'b011: {link_next, ac_next} = {ac[1:11], link, ac[0]};  // rtl
                        3'b100: {link_next, ac_next} = {ac[11], link, ac[0:10]};  // rar
                        3'b101: {link_next, ac_next} = {ac[10:11], link, ac[0:9]};  // rtr
                        default: op_we = 1'b0;
                    endcase
                end
            pdp8_pkg::E2:
                case (instruction.mem.opcode)
                    pdp8_pkg::OP_AND:
                    begin
                        op_we   = 1'b1;
                        ac_next = ac & operand;
                    end
                    pdp8_pkg::OP_TAD:
                    begin
                        op_we                = 1'b1;
                        {link_next, ac_next} = {link, ac} + {1'b0, operand};  // carry flips link
                    end
                    default: ;
                endcase
            pdp8_pkg::E3:
                if (instruction.mem.opcode == pdp8_pkg::OP_DCA)
                begin
                    op_we   = 1'b1;
                    ac_next = 12'o0000;  // ac already went to memory
                end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/phase_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module phase_sequencer (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             start,
    input  wire pdp8_pkg::instr_t instruction,
    input  wire logic             eae_loop,
    output pdp8_pkg::phase_t      phase,
    output logic                  busy,
    output logic                  done
);

    pdp8_pkg::word_t  code;
    pdp8_pkg::phase_t first_phase;

    assign code = instruction;

    // entry phase picked from the opcode
    always_comb
    begin
        case (instruction.mem.opcode)
            pdp8_pkg::OP_AND,
            pdp8_pkg::OP_TAD,
            pdp8_pkg::OP_DCA: first_phase = pdp8_pkg::E2;
            pdp8_pkg::OP_OPR:
                case (code)
                    pdp8_pkg::EAE_MUL,
                    pdp8_pkg::EAE_DIV,
                    pdp8_pkg::EAE_SHL,
                    pdp8_pkg::EAE_ASR,
                    pdp8_pkg::EAE_LSR: first_phase = pdp8_pkg::EAE0;
                    default:           first_phase = pdp8_pkg::F1;
                endcase
            default: first_phase = pdp8_pkg::F1;  // iot and the rest run as a no-op
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= pdp8_pkg::IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (phase)
                pdp8_pkg::IDLE:
                    if (start)
                    begin
                        phase <= first_phase;
                        busy  <= 1'b1;
                    end
                pdp8_pkg::F1:   phase <= pdp8_pkg::F2;
                pdp8_pkg::F2:   phase <= pdp8_pkg::F3;
                pdp8_pkg::E2:   phase <= pdp8_pkg::E3;
                pdp8_pkg::EAE0: phase <= pdp8_pkg::EAE1;
                pdp8_pkg::EAE1:
                    if (!eae_loop)  // last step already written
                    begin
                        phase <= pdp8_pkg::IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                default:  // F3, E3
                begin
                    phase <= pdp8_pkg::IDLE;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done);

    idle_when_free: assert property (@(posedge clk) disable iff (reset)
        !busy |-> phase == pdp8_pkg::IDLE);

endmodule

`default_nettype wire

// File: common/pdp8_pkg.sv
`default_nettype none

package pdp8_pkg;

    typedef logic [0:11] word_t;  // bit 0 is the msb, as on the pdp-8

    typedef logic [0:4] sc_t;  // eae step counter

    // memory reference layout
    typedef struct packed {
        logic [0:2] opcode;
        logic       indirect;
        logic       page;  // set for current page
        logic [0:6] offset;
    } mem_view_t;

    // operate layout, group 1 bit names
    typedef struct packed {
        logic [0:2] opcode;
        logic       group;  // 0 selects group 1
        logic       cla;
        logic       cll;
        logic       cma;
        logic       cml;
        logic       rar;
        logic       ral;
        logic       bsw;  // doubles a rotate, or swaps bytes alone
        logic       iac;
    } opr_view_t;

    typedef union packed {
        mem_view_t mem;
        opr_view_t opr;
    } instr_t;

    typedef enum logic [3:0] {
        IDLE,
        F1,    // operate, clear and complement
        F2,    // operate, increment
        F3,    // operate, rotate
        E2,    // and, tad
        E3,    // dca
        EAE0,  // eae setup
        EAE1   // eae iteration
    } phase_t;

    localparam logic [0:2] OP_AND = 3'o0;
    localparam logic [0:2] OP_TAD = 3'o1;
    localparam logic [0:2] OP_DCA = 3'o3;
    localparam logic [0:2] OP_OPR = 3'o7;

    localparam word_t EAE_MUL = 12'o7405;
    localparam word_t EAE_DIV = 12'o7407;
    localparam word_t EAE_SHL = 12'o7413;
    localparam word_t EAE_ASR = 12'o7415;
    localparam word_t EAE_LSR = 12'o7417;

    localparam word_t MQ_MQL = 12'o7421;
    localparam word_t MQ_MQA = 12'o7501;
    localparam word_t MQ_SWP = 12'o7521;
    localparam word_t MQ_CLA = 12'o7601;
    localparam word_t MQ_CAM = 12'o7621;
    localparam word_t MQ_ACL = 12'o7701;

    localparam int SHIFT_LIMIT = 24;  // shift field value that clears everything

endpackage

`default_nettype wire
